// ==== hdl/tcm_defs.svh ====
`ifndef TCM_DEFS_SVH
`define TCM_DEFS_SVH

// ----------------------------------------------------------------------
// Geometry of the tightly coupled memory
// ----------------------------------------------------------------------

// Each RAM line is split into byte columns with their own write enable
`define TCM_NUM_COL 8
`define TCM_COL_WIDTH 8

// Line address width gives 1024 lines of 64 bits
`define TCM_ADDR_WIDTH 10
`define TCM_LINE_WIDTH (`TCM_NUM_COL * `TCM_COL_WIDTH)

// Byte addresses carry three extra bits for the offset inside a line
`define TCM_BYTE_ADDR_WIDTH (`TCM_ADDR_WIDTH + 3)

`endif

// ==== hdl/ram_pkg.sv ====
`include "tcm_defs.svh"

package ram_pkg;

	// Instructions are always 32 bits wide in this core
	typedef logic [31:0] instr_t;

	// ----------------------------------------------------------------------
	// One RAM line, read as bytes by the load/store side and as
	// instruction words by the fetch side
	// ----------------------------------------------------------------------
	typedef union packed {
		// Byte lanes, lane 0 holds the lowest addressed byte
		logic [`TCM_NUM_COL-1:0][`TCM_COL_WIDTH-1:0] bytes;
		// Two instruction words, word 0 at the lower address
		instr_t [`TCM_LINE_WIDTH/32-1:0] words;
	} line_t;

endpackage

// ==== hdl/lsu_pkg.sv ====
`include "tcm_defs.svh"

package lsu_pkg;

	// Access sizes as encoded on the load/store interface
	typedef enum logic [1:0] {
		size_byte  = 2'd0,
		size_half  = 2'd1,
		size_word  = 2'd2,
		size_dword = 2'd3
	} access_size_e;

	// Load and store data are one full line wide
	typedef logic [`TCM_LINE_WIDTH-1:0] data_t;

endpackage

// ==== hdl/bram1p1rw.sv ====
`include "tcm_defs.svh"

module bram1p1rw (
	input  logic                        clk,
	input  logic                        we,
	input  logic [`TCM_NUM_COL-1:0]     bwe,
	input  logic [`TCM_ADDR_WIDTH-1:0]  addr,
	input  ram_pkg::line_t              din,
	output ram_pkg::line_t              dout
);

	// Storage array, one entry per line
	logic [`TCM_LINE_WIDTH-1:0] mem [0:(2**`TCM_ADDR_WIDTH)-1];

	// ----------------------------------------------------------------------
	// Single port with a registered read
	// ----------------------------------------------------------------------

	// The read always happens and returns the contents before any write
	// at the same edge, so a read during a write sees old data
	always_ff @(posedge clk) begin
		dout <= mem[addr];
		if (we) begin
			// Only the columns with their enable set are updated
			for (int i = 0; i < `TCM_NUM_COL; i++) begin
				if (bwe[i]) begin
					mem[addr][i*`TCM_COL_WIDTH +: `TCM_COL_WIDTH] <= din.bytes[i];
				end
			end
		end
	end

endmodule

// ==== hdl/tcm_arbiter.sv ====
`include "tcm_defs.svh"

module tcm_arbiter (
	input  logic                        clk,
	input  logic                        arst_n,
	// Load/store requester
	input  logic                        lsu_req,
	input  logic                        lsu_we,
	input  logic [`TCM_NUM_COL-1:0]     lsu_bwe,
	input  logic [`TCM_ADDR_WIDTH-1:0]  lsu_addr,
	input  ram_pkg::line_t              lsu_wdata,
	output logic                        lsu_gnt,
	// Fetch requester, read only
	input  logic                        if_ram_req,
	input  logic [`TCM_ADDR_WIDTH-1:0]  if_ram_addr,
	output logic                        if_gnt,
	// Shared RAM port
	output logic                        ram_we,
	output logic [`TCM_NUM_COL-1:0]     ram_bwe,
	output logic [`TCM_ADDR_WIDTH-1:0]  ram_addr,
	output ram_pkg::line_t              ram_din
);

	// Set when the load/store port got the most recent grant
	logic last_lsu;

	// ----------------------------------------------------------------------
	// Round-robin choice
	// ----------------------------------------------------------------------

	// Load/store wins when alone or when fetch had the last grant
	assign lsu_gnt = lsu_req && (!if_ram_req || !last_lsu);

	// Fetch takes whatever load/store does not
	assign if_gnt = if_ram_req && !lsu_gnt;

	// Reset points at fetch so the first tie goes to load/store
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			last_lsu <= 1'b0;
		end else if (lsu_gnt) begin
			last_lsu <= 1'b1;
		end else if (if_gnt) begin
			last_lsu <= 1'b0;
		end
	end

	// ----------------------------------------------------------------------
	// RAM port steering
	// ----------------------------------------------------------------------

	// Address follows the winner, fetch owns it otherwise
	assign ram_addr = lsu_gnt ? lsu_addr : if_ram_addr;

	// Only a granted load/store write may touch the array
	assign ram_we = lsu_gnt && lsu_we;

	// Column enables are cleared whenever no write goes out
	assign ram_bwe = ram_we ? lsu_bwe : '0;

	// Write data has a single source since fetch never writes
	assign ram_din = lsu_wdata;

endmodule

// ==== hdl/lsu_port.sv ====
`include "tcm_defs.svh"

module lsu_port (
	input  logic                             clk,
	input  logic                             arst_n,
	// External load/store interface
	input  logic                             mem_req,
	input  logic                             mem_we,
	input  lsu_pkg::access_size_e            mem_size,
	input  logic                             mem_signed,
	input  logic [`TCM_BYTE_ADDR_WIDTH-1:0]  mem_addr,
	input  lsu_pkg::data_t                   mem_wdata,
	output lsu_pkg::data_t                   mem_rdata,
	output logic                             mem_done,
	// Request towards the arbiter
	output logic                             lsu_req,
	output logic                             lsu_we,
	output logic [`TCM_NUM_COL-1:0]          lsu_bwe,
	output logic [`TCM_ADDR_WIDTH-1:0]       lsu_addr,
	output ram_pkg::line_t                   lsu_wdata,
	input  logic                             lsu_gnt,
	// Read line from the RAM
	input  ram_pkg::line_t                   ram_dout
);

	// Offset inside the line after alignment to the access size
	logic [2:0] off;
	// Lane mask for replication, one less than the access size in bytes
	logic [2:0] lane_mask;
	// Byte enable pattern before it is moved to the offset
	logic [`TCM_NUM_COL-1:0] size_mask;

	// Access that was granted last cycle
	logic                  busy;
	logic [2:0]            pend_off;
	lsu_pkg::access_size_e pend_size;
	logic                  pend_signed;

	// Read line moved down so the addressed byte sits in lane 0
	lsu_pkg::data_t line_bits;
	lsu_pkg::data_t shifted;

	// ----------------------------------------------------------------------
	// Request side
	// ----------------------------------------------------------------------

	// Misaligned addresses are rounded down inside the access size
	always_comb begin
		case (mem_size)
			lsu_pkg::size_byte: begin
				off       = mem_addr[2:0];
				lane_mask = 3'd0;
				size_mask = 8'h01;
			end
			lsu_pkg::size_half: begin
				off       = {mem_addr[2:1], 1'b0};
				lane_mask = 3'd1;
				size_mask = 8'h03;
			end
			lsu_pkg::size_word: begin
				off       = {mem_addr[2], 2'b00};
				lane_mask = 3'd3;
				size_mask = 8'h0f;
			end
			default: begin
				off       = 3'd0;
				lane_mask = 3'd7;
				size_mask = 8'hff;
			end
		endcase
	end

	// Store data is copied into every lane group so each offset finds it
	always_comb begin
		for (int i = 0; i < `TCM_NUM_COL; i++) begin
			lsu_wdata.bytes[i] = mem_wdata[`TCM_COL_WIDTH*(i & lane_mask) +: `TCM_COL_WIDTH];
		end
	end

	// No new request while the granted one is completing
	assign lsu_req  = mem_req && !busy;
	assign lsu_we   = mem_we;
	assign lsu_bwe  = size_mask << off;
	assign lsu_addr = mem_addr[`TCM_BYTE_ADDR_WIDTH-1:3];

	// ----------------------------------------------------------------------
	// Completion and load return
	// ----------------------------------------------------------------------

	// Done follows the grant by one cycle, the same cycle the line arrives
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
		end else begin
			busy <= lsu_gnt;
		end
	end

	assign mem_done = busy;

	// Details of the granted access, kept for formatting the returned line
	always_ff @(posedge clk) begin
		if (lsu_gnt) begin
			pend_off    <= off;
			pend_size   <= mem_size;
			pend_signed <= mem_signed;
		end
	end

	assign line_bits = ram_dout;
	assign shifted   = line_bits >> {pend_off, 3'b000};

	// Extend with zeros or with the top bit of the accessed field
	always_comb begin
		case (pend_size)
			lsu_pkg::size_byte: mem_rdata = {{56{pend_signed & shifted[7]}}, shifted[7:0]};
			lsu_pkg::size_half: mem_rdata = {{48{pend_signed & shifted[15]}}, shifted[15:0]};
			lsu_pkg::size_word: mem_rdata = {{32{pend_signed & shifted[31]}}, shifted[31:0]};
			default:            mem_rdata = shifted;
		endcase
	end

endmodule

// ==== hdl/fetch_port.sv ====
`include "tcm_defs.svh"

module fetch_port (
	input  logic                             clk,
	input  logic                             arst_n,
	// External fetch interface
	input  logic                             if_req,
	input  logic [`TCM_BYTE_ADDR_WIDTH-1:0]  if_addr,
	output ram_pkg::instr_t                  if_instr,
	output logic                             if_valid,
	// Request towards the arbiter
	output logic                             if_ram_req,
	output logic [`TCM_ADDR_WIDTH-1:0]       if_ram_addr,
	input  logic                             if_gnt,
	// Shared RAM port, read data and the write being issued
	input  ram_pkg::line_t                   ram_dout,
	input  logic                             ram_we,
	input  logic [`TCM_ADDR_WIDTH-1:0]       ram_addr
);

	// The one buffered line with its line address
	ram_pkg::line_t              buf_line;
	logic [`TCM_ADDR_WIDTH-1:0]  buf_tag;
	logic                        buf_valid;

	// Response states, each lasts exactly one cycle
	logic hit_q;
	logic fill_q;
	logic busy;
	logic hit;

	// ----------------------------------------------------------------------
	// Lookup and request
	// ----------------------------------------------------------------------

	assign if_ram_addr = if_addr[`TCM_BYTE_ADDR_WIDTH-1:3];
	assign hit         = buf_valid && (buf_tag == if_ram_addr);
	assign busy        = hit_q || fill_q;

	// Misses go to the RAM; hits never disturb the arbiter
	assign if_ram_req = if_req && !busy && !hit;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hit_q  <= 1'b0;
			fill_q <= 1'b0;
		end else begin
			hit_q  <= if_req && !busy && hit;
			fill_q <= if_gnt;
		end
	end

	// ----------------------------------------------------------------------
	// Response
	// ----------------------------------------------------------------------

	// if_addr is still held in the response cycle, so bit 2 picks the word
	assign if_valid = busy;
	assign if_instr = fill_q ? ram_dout.words[if_addr[2]] : buf_line.words[if_addr[2]];

	// ----------------------------------------------------------------------
	// Buffer fill and snooping
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (fill_q) begin
			buf_line <= ram_dout;
			buf_tag  <= if_ram_addr;
		end
	end

	// A write in the fill cycle was read before it landed, so the fresh
	// line is already stale and stays invalid
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			buf_valid <= 1'b0;
		end else if (fill_q) begin
			buf_valid <= !(ram_we && (ram_addr == if_ram_addr));
		end else if (ram_we && (ram_addr == buf_tag)) begin
			buf_valid <= 1'b0;
		end
	end

endmodule

// ==== hdl/tcm_top.sv ====
`include "tcm_defs.svh"

module tcm_top (
	input  logic                             clk,
	input  logic                             arst_n,
	// Load/store side
	input  logic                             mem_req,
	input  logic                             mem_we,
	input  lsu_pkg::access_size_e            mem_size,
	input  logic                             mem_signed,
	input  logic [`TCM_BYTE_ADDR_WIDTH-1:0]  mem_addr,
	input  lsu_pkg::data_t                   mem_wdata,
	output lsu_pkg::data_t                   mem_rdata,
	output logic                             mem_done,
	// Fetch side
	input  logic                             if_req,
	input  logic [`TCM_BYTE_ADDR_WIDTH-1:0]  if_addr,
	output ram_pkg::instr_t                  if_instr,
	output logic                             if_valid
);

	// Load/store requester to arbiter
	logic                        lsu_req;
	logic                        lsu_we;
	logic [`TCM_NUM_COL-1:0]     lsu_bwe;
	logic [`TCM_ADDR_WIDTH-1:0]  lsu_addr;
	ram_pkg::line_t              lsu_wdata;
	logic                        lsu_gnt;

	// Fetch requester to arbiter
	logic                        if_ram_req;
	logic [`TCM_ADDR_WIDTH-1:0]  if_ram_addr;
	logic                        if_gnt;

	// Arbiter to RAM and the shared read line
	logic                        ram_we;
	logic [`TCM_NUM_COL-1:0]     ram_bwe;
	logic [`TCM_ADDR_WIDTH-1:0]  ram_addr;
	ram_pkg::line_t              ram_din;
	ram_pkg::line_t              ram_dout;

	// ----------------------------------------------------------------------
	// Requesters, arbiter and storage
	// ----------------------------------------------------------------------

	lsu_port u_lsu (
		.clk, .arst_n, .mem_req, .mem_we, .mem_size, .mem_signed, .mem_addr,
		.mem_wdata, .mem_rdata, .mem_done, .lsu_req, .lsu_we, .lsu_bwe,
		.lsu_addr, .lsu_wdata, .lsu_gnt, .ram_dout
	);

	fetch_port u_fetch (
		.clk, .arst_n, .if_req, .if_addr, .if_instr, .if_valid, .if_ram_req,
		.if_ram_addr, .if_gnt, .ram_dout, .ram_we, .ram_addr
	);

	tcm_arbiter u_arb (
		.clk, .arst_n, .lsu_req, .lsu_we, .lsu_bwe, .lsu_addr, .lsu_wdata,
		.lsu_gnt, .if_ram_req, .if_ram_addr, .if_gnt, .ram_we, .ram_bwe,
		.ram_addr, .ram_din
	);

	bram1p1rw u_ram (
		.clk,
		.we   (ram_we),
		.bwe  (ram_bwe),
		.addr (ram_addr),
		.din  (ram_din),
		.dout (ram_dout)
	);

endmodule

// ==== verif/tcm_chk.sv ====
module tcm_chk (
	input logic clk,
	input logic arst_n,
	input logic lsu_gnt,
	input logic if_gnt,
	input logic ram_we,
	input logic mem_req,
	input logic mem_done,
	input logic if_req,
	input logic if_valid
);

	// ----------------------------------------------------------------------
	// Arbiter rules
	// ----------------------------------------------------------------------

	// The RAM port has a single owner per cycle
	grant_excl: assert property (@(posedge clk) disable iff (!arst_n)
		!(lsu_gnt && if_gnt)) else $error("both grants high together");

	// Fetch never writes, so a write must come from a load/store grant
	we_with_gnt: assert property (@(posedge clk) disable iff (!arst_n)
		ram_we |-> lsu_gnt) else $error("ram_we without lsu_gnt");

	// ----------------------------------------------------------------------
	// Port completion rules
	// ----------------------------------------------------------------------

	// Once the requester lets go after a completion, no second completion follows
	done_single: assert property (@(posedge clk) disable iff (!arst_n)
		(mem_done ##1 !mem_req) |-> !mem_done)
		else $error("mem_done repeated without mem_req");

	// A fetch response always answers a request from the cycle before
	valid_after_req: assert property (@(posedge clk) disable iff (!arst_n)
		if_valid |-> $past(if_req)) else $error("if_valid without prior if_req");

endmodule

bind tcm_top tcm_chk chk (.clk, .arst_n, .lsu_gnt, .if_gnt, .ram_we, .mem_req,
	.mem_done, .if_req, .if_valid);

// ==== verif/tcm_tb.sv ====
`include "tcm_defs.svh"

module tcm_tb;

	typedef logic [`TCM_BYTE_ADDR_WIDTH-1:0] addr_t;

	logic                  clk;
	logic                  arst_n;
	logic                  mem_req;
	logic                  mem_we;
	lsu_pkg::access_size_e mem_size;
	logic                  mem_signed;
	addr_t                 mem_addr;
	lsu_pkg::data_t        mem_wdata;
	lsu_pkg::data_t        mem_rdata;
	logic                  mem_done;
	logic                  if_req;
	addr_t                 if_addr;
	ram_pkg::instr_t       if_instr;
	logic                  if_valid;

	// Byte image of the RAM, lowest address in entry 0
	logic [7:0]  ref_mem [0:2**`TCM_BYTE_ADDR_WIDTH-1];
	logic [31:0] rng_state;

	tcm_top uut (.*);

	always #10 clk = ~clk;

	// ----------------------------------------------------------------------
	// Reporting and compare tasks
	// ----------------------------------------------------------------------

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at %0t", $time);
	endtask

	task automatic check_data(input string name, input lsu_pkg::data_t got,
			input lsu_pkg::data_t exp);
		if (got !== exp)
			stop_on_error($sformatf("Mismatch at %0t: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_instr(input string name, input ram_pkg::instr_t got,
			input ram_pkg::instr_t exp);
		if (got !== exp)
			stop_on_error($sformatf("Mismatch at %0t: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	// ----------------------------------------------------------------------
	// Reference model and random source
	// ----------------------------------------------------------------------

	// Xorshift step, state is shared by all tests
	function automatic logic [31:0] next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic lsu_pkg::data_t rand_data();
		lsu_pkg::data_t d;
		d[63:32] = next_rand();
		d[31:0]  = next_rand();
		return d;
	endfunction

	// Access start with the low bits dropped inside the access size
	function automatic addr_t align_down(input addr_t addr, input lsu_pkg::access_size_e size);
		return addr & ~addr_t'((1 << size) - 1);
	endfunction

	// Load result from the byte image, extended with zeros or the sign
	function automatic lsu_pkg::data_t ref_load(input addr_t addr,
			input lsu_pkg::access_size_e size, input logic sgn);
		lsu_pkg::data_t v;
		addr_t          base;
		int             nbytes;
		logic           ext;
		nbytes = 1 << size;
		base   = align_down(addr, size);
		v      = '0;
		for (int i = 0; i < 8; i++)
			if (i < nbytes)
				v[8*i +: 8] = ref_mem[base + addr_t'(i)];
		ext = sgn & v[8*nbytes-1];
		for (int i = 0; i < 8; i++)
			if (i >= nbytes)
				v[8*i +: 8] = {8{ext}};
		return v;
	endfunction

	// Instruction words are little endian, bit 2 picks the half of the line
	function automatic ram_pkg::instr_t ref_instr(input addr_t addr);
		return {ref_mem[{addr[12:2], 2'd3}], ref_mem[{addr[12:2], 2'd2}],
			ref_mem[{addr[12:2], 2'd1}], ref_mem[{addr[12:2], 2'd0}]};
	endfunction

	// ----------------------------------------------------------------------
	// Bus drivers, each waits at most three cycles for its completion
	// ----------------------------------------------------------------------

	task automatic mem_access(input logic we, input lsu_pkg::access_size_e size,
			input logic sgn, input addr_t addr, input lsu_pkg::data_t wdata,
			output lsu_pkg::data_t rdata);
		bit seen;
		seen       = 1'b0;
		mem_req    = 1'b1;
		mem_we     = we;
		mem_size   = size;
		mem_signed = sgn;
		mem_addr   = addr;
		mem_wdata  = wdata;
		for (int n = 0; n < 3 && !seen; n++) begin
			@(negedge clk);
			seen = mem_done;
		end
		if (!seen)
			stop_on_error("Load/store request saw no mem_done within three cycles");
		rdata = mem_rdata;
		@(posedge clk);
		#1;
		mem_req = 1'b0;
	endtask

	task automatic do_store(input lsu_pkg::access_size_e size, input addr_t addr,
			input lsu_pkg::data_t wdata);
		lsu_pkg::data_t unused_rdata;
		mem_access(1'b1, size, 1'b0, addr, wdata, unused_rdata);
		// Data byte k lands at the aligned start plus k
		for (int i = 0; i < (1 << size); i++)
			ref_mem[align_down(addr, size) + addr_t'(i)] = wdata[8*i +: 8];
	endtask

	task automatic do_load_check(input lsu_pkg::access_size_e size, input logic sgn,
			input addr_t addr);
		lsu_pkg::data_t got;
		mem_access(1'b0, size, sgn, addr, '0, got);
		check_data("mem_rdata", got, ref_load(addr, size, sgn));
	endtask

	task automatic fetch_check(input addr_t addr);
		bit              seen;
		ram_pkg::instr_t got;
		seen    = 1'b0;
		if_req  = 1'b1;
		if_addr = addr;
		for (int n = 0; n < 3 && !seen; n++) begin
			@(negedge clk);
			seen = if_valid;
		end
		if (!seen)
			stop_on_error("Fetch request saw no if_valid within three cycles");
		got = if_instr;
		@(posedge clk);
		#1;
		if_req = 1'b0;
		check_instr("if_instr", got, ref_instr(addr));
	endtask

	// ----------------------------------------------------------------------
	// Directed tests
	// ----------------------------------------------------------------------

	task automatic test_dword();
		int lines [5] = '{0, 1, 37, 512, 1023};
		foreach (lines[i])
			do_store(lsu_pkg::size_dword, addr_t'(lines[i] * 8), rand_data());
		foreach (lines[i])
			do_load_check(lsu_pkg::size_dword, 1'b0, addr_t'(lines[i] * 8));
	endtask

	// Every offset is tried, so misaligned ones check the rounding too
	task automatic test_subword();
		addr_t                 base;
		lsu_pkg::access_size_e size;
		base = addr_t'(5 * 8);
		do_store(lsu_pkg::size_dword, base, 64'h8877_6655_4433_2211);
		for (int s = 0; s < 3; s++) begin
			size = lsu_pkg::access_size_e'(s);
			for (int off = 0; off < 8; off++) begin
				do_store(size, base + addr_t'(off), rand_data());
				do_load_check(lsu_pkg::size_dword, 1'b0, base);
				do_load_check(size, 1'b0, base + addr_t'(off));
				do_load_check(size, 1'b1, base + addr_t'(off));
			end
		end
	endtask

	// The second fetch of each line is served from the buffer
	task automatic test_fetch();
		do_store(lsu_pkg::size_dword, addr_t'(100 * 8), rand_data());
		do_store(lsu_pkg::size_dword, addr_t'(101 * 8), rand_data());
		fetch_check(addr_t'(100 * 8));
		fetch_check(addr_t'(100 * 8 + 4));
		fetch_check(addr_t'(101 * 8 + 4));
		fetch_check(addr_t'(101 * 8));
	endtask

	task automatic test_snoop();
		fetch_check(addr_t'(101 * 8));
		do_store(lsu_pkg::size_word, addr_t'(101 * 8), rand_data());
		fetch_check(addr_t'(101 * 8));
		fetch_check(addr_t'(101 * 8 + 4));
	endtask

	// Both sides request in the same cycle, fetch misses each time
	task automatic test_contention();
		for (int i = 200; i < 203; i++)
			do_store(lsu_pkg::size_dword, addr_t'(i * 8), rand_data());
		fork
			do_load_check(lsu_pkg::size_dword, 1'b0, addr_t'(200 * 8));
			fetch_check(addr_t'(201 * 8 + 4));
		join
		fork
			do_load_check(lsu_pkg::size_word, 1'b1, addr_t'(200 * 8 + 4));
			fetch_check(addr_t'(202 * 8));
		join
	endtask

	task automatic test_random();
		logic [31:0] r;
		for (int i = 0; i < 16; i++)
			do_store(lsu_pkg::size_dword, addr_t'(i * 8), rand_data());
		for (int i = 0; i < 200; i++) begin
			r = next_rand();
			if (r[0])
				do_store(lsu_pkg::access_size_e'(r[2:1]), addr_t'(r[10:4]), rand_data());
			else
				do_load_check(lsu_pkg::access_size_e'(r[2:1]), r[3], addr_t'(r[10:4]));
		end
	endtask

	initial begin
		clk        = 1'b0;
		arst_n     = 1'b0;
		mem_req    = 1'b0;
		mem_we     = 1'b0;
		mem_size   = lsu_pkg::size_byte;
		mem_signed = 1'b0;
		mem_addr   = '0;
		mem_wdata  = '0;
		if_req     = 1'b0;
		if_addr    = '0;
		rng_state  = 32'h58a24f9b;
		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(posedge clk);
		#1;
		test_dword();
		test_subword();
		test_fetch();
		test_snoop();
		test_contention();
		test_random();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+hdl
hdl/ram_pkg.sv
hdl/lsu_pkg.sv
hdl/bram1p1rw.sv
hdl/tcm_arbiter.sv
hdl/lsu_port.sv
hdl/fetch_port.sv
hdl/tcm_top.sv
verif/tcm_chk.sv
verif/tcm_tb.sv

// ==== Makefile ====
TOP := tcm_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f

# The run fails unless the pass line shows up in the simulator output
run: build
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir
